//--- build.f
+incdir+dv
rtl/rrag_pkg.sv
rtl/ptc_generator.sv
rtl/regfile.sv
rtl/segfile.sv
rtl/addr_gen.sv
rtl/rrag.sv
dv/rrag_tb.sv

//--- dv/rrag_tests.svh
// Bits kept by a byte, word or dword access
function automatic rrag_pkg::gpr_t size_mask(input rrag_pkg::opsize_t size);
    case (size)
        2'd0:    return 32'h0000_00ff;
        2'd1:    return 32'h0000_ffff;
        default: return 32'hffff_ffff;
    endcase
endfunction

task automatic idle_inputs();
    {valid_in, latch_empty, fwd_stall, ptc_clear, usereg2, usereg3, is_rep_in} = '0;
    {reg_addr1, reg_addr2, reg_addr3, reg_addr4} = '0;
    {seg_addr1, seg_addr2, seg_addr3, seg_addr4} = '0;
    {opsize_in, reg3_shfamnt, mem1_rw, mem2_rw, disp, dest_gpr, dest_seg} = '0;
    {wba_data, wba_addr, wba_regld, wba_opsize} = '0;
    {wba_segdata, wba_segaddr, wba_segld, wba_ptcid} = '0;
    {wbb_data, wbb_addr, wbb_regld, wbb_opsize} = '0;
    {wbb_segdata, wbb_segaddr, wbb_segld, wbb_ptcid} = '0;
endtask

// Both ports load a register pair per cycle
task automatic load_random_regs();
    {wba_regld, wbb_regld, wba_segld, wbb_segld} = 4'b1111;
    wba_opsize = 2'd2;
    wbb_opsize = 2'd3;
    for (int r = 0; r < rrag_pkg::NUM_REGS; r += 2) begin
        wba_addr = rrag_pkg::reg_idx_t'(r);
        wbb_addr = rrag_pkg::reg_idx_t'(r + 1);
        wba_segaddr = rrag_pkg::reg_idx_t'(r);
        wbb_segaddr = rrag_pkg::reg_idx_t'(r + 1);
        wba_data = $urandom;
        wbb_data = $urandom;
        wba_segdata = rrag_pkg::seg_t'($urandom);
        wbb_segdata = rrag_pkg::seg_t'($urandom);
        gpr_model[r] = wba_data;
        gpr_model[r + 1] = wbb_data;
        seg_model[r] = wba_segdata;
        seg_model[r + 1] = wbb_segdata;
        @(negedge clk);
    end
    {wba_regld, wbb_regld, wba_segld, wbb_segld} = '0;
endtask

task automatic drive_writeback(input bit is_seg, input int idx, input rrag_pkg::ptcid_t id);
    if (is_seg) begin
        wbb_segld = 1'b1;
        wbb_segaddr = rrag_pkg::reg_idx_t'(idx);
        wbb_segdata = rrag_pkg::seg_t'($urandom);
        wbb_ptcid = id;
        seg_model[idx] = wbb_segdata;
    end else begin
        wba_regld = 1'b1;
        wba_addr = rrag_pkg::reg_idx_t'(idx);
        wba_opsize = 2'd2;
        wba_data = $urandom;
        wba_ptcid = id;
        gpr_model[idx] = wba_data;
    end
    @(negedge clk);
    {wba_regld, wbb_segld} = '0;
endtask

task automatic pend_scan(input logic exp, input string what);
    for (int r = 0; r < rrag_pkg::NUM_REGS; r++) begin
        {reg_addr1, reg_addr2, reg_addr3, reg_addr4} = {4{rrag_pkg::reg_idx_t'(r)}};
        {seg_addr1, seg_addr2, seg_addr3, seg_addr4} = {4{rrag_pkg::reg_idx_t'(r)}};
        #1;
        compare_bit({what, " gpr port 1"}, exp, r_pend1);
        compare_bit({what, " gpr port 2"}, exp, r_pend2);
        compare_bit({what, " gpr port 3"}, exp, r_pend3);
        compare_bit({what, " gpr port 4"}, exp, r_pend4);
        compare_bit({what, " seg port 1"}, exp, s_pend1);
        compare_bit({what, " seg port 2"}, exp, s_pend2);
        compare_bit({what, " seg port 3"}, exp, s_pend3);
        compare_bit({what, " seg port 4"}, exp, s_pend4);
        @(negedge clk);
    end
endtask

task automatic sized_access();
    load_random_regs();
    // Byte into r1 and word into r6 keep the upper bits
    {wba_regld, wbb_regld} = 2'b11;
    wba_addr = 3'd1;
    wba_opsize = 2'd0;
    wba_data = $urandom;
    wbb_addr = 3'd6;
    wbb_opsize = 2'd1;
    wbb_data = $urandom;
    gpr_model[1] = (gpr_model[1] & ~size_mask(2'd0)) | (wba_data & size_mask(2'd0));
    gpr_model[6] = (gpr_model[6] & ~size_mask(2'd1)) | (wbb_data & size_mask(2'd1));
    @(negedge clk);
    {wba_regld, wbb_regld} = '0;
    for (int s = 0; s < 4; s++) begin
        opsize_in = rrag_pkg::opsize_t'(s);
        for (int r = 0; r < rrag_pkg::NUM_REGS; r++) begin
            {reg_addr1, seg_addr1} = {2{rrag_pkg::reg_idx_t'(r)}};
            {reg_addr2, seg_addr2} = {2{rrag_pkg::reg_idx_t'(r + 1)}};
            {reg_addr3, seg_addr3} = {2{rrag_pkg::reg_idx_t'(r + 2)}};
            {reg_addr4, seg_addr4} = {2{rrag_pkg::reg_idx_t'(r + 3)}};
            #1;
            compare_gpr("reg1", gpr_model[r] & size_mask(opsize_in), reg1);
            compare_gpr("reg2", gpr_model[(r + 1) % 8] & size_mask(opsize_in), reg2);
            compare_gpr("reg3", gpr_model[(r + 2) % 8] & size_mask(opsize_in), reg3);
            compare_gpr("reg4", gpr_model[(r + 3) % 8] & size_mask(opsize_in), reg4);
            compare_seg("seg1", seg_model[r], seg1);
            compare_seg("seg2", seg_model[(r + 1) % 8], seg2);
            compare_seg("seg3", seg_model[(r + 2) % 8], seg3);
            compare_seg("seg4", seg_model[(r + 3) % 8], seg4);
            @(negedge clk);
        end
    end
endtask

task automatic address_math();
    rrag_pkg::addr_t offset;
    rrag_pkg::addr_t span;
    rrag_pkg::addr_t r4;
    load_random_regs();
    for (int i = 0; i < 24; i++) begin
        @(negedge clk);
        reg_addr2 = rrag_pkg::reg_idx_t'($urandom);
        reg_addr3 = rrag_pkg::reg_idx_t'($urandom);
        reg_addr4 = rrag_pkg::reg_idx_t'($urandom);
        seg_addr1 = rrag_pkg::reg_idx_t'($urandom);
        seg_addr2 = rrag_pkg::reg_idx_t'($urandom);
        usereg2 = 1'($urandom);
        usereg3 = 1'($urandom);
        reg3_shfamnt = rrag_pkg::shamt_t'($urandom);
        opsize_in = rrag_pkg::opsize_t'($urandom);
        disp = $urandom;
        offset = usereg2 ? (gpr_model[reg_addr2] & size_mask(opsize_in)) : '0;
        if (usereg3)
            offset += (gpr_model[reg_addr3] & size_mask(opsize_in)) << reg3_shfamnt;
        span = rrag_pkg::addr_t'((2 ** opsize_in) - 1);
        r4 = gpr_model[reg_addr4] & size_mask(opsize_in);
        #1;
        compare_addr("mem_addr1", offset + disp +
            (rrag_pkg::addr_t'(seg_model[seg_addr1]) << rrag_pkg::SEG_SHIFT), mem_addr1);
        compare_addr("mem_addr1_end", offset + disp + span, mem_addr1_end);
        compare_addr("mem_addr2",
            r4 + (rrag_pkg::addr_t'(seg_model[seg_addr2]) << rrag_pkg::SEG_SHIFT), mem_addr2);
        compare_addr("mem_addr2_end", r4 + span, mem_addr2_end);
    end
    @(negedge clk);
    {usereg2, usereg3, reg3_shfamnt, disp} = '0;
endtask

task automatic pending_case(input bit is_seg, input int idx);
    rrag_pkg::ptcid_t tag;
    @(negedge clk);
    valid_in = 1'b1;
    if (is_seg)
        dest_seg = rrag_pkg::reg_mask_t'(1 << idx);
    else
        dest_gpr = rrag_pkg::reg_mask_t'(1 << idx);
    #1;
    compare_ptcid("tag at issue", exp_ptcid, inst_ptcid);
    tag = exp_ptcid;
    @(negedge clk);
    exp_ptcid++;
    {dest_gpr, dest_seg} = '0;
    if (is_seg) begin
        mem2_rw = 2'b10;
        seg_addr2 = rrag_pkg::reg_idx_t'(idx);
        reg_addr4 = rrag_pkg::reg_idx_t'(idx + 1);
    end else begin
        mem1_rw = 2'b01;
        usereg2 = 1'b1;
        reg_addr2 = rrag_pkg::reg_idx_t'(idx);
        seg_addr1 = rrag_pkg::reg_idx_t'(idx + 1);
    end
    #1;
    compare_bit("stall on pending operand", 1'b1, stall);
    compare_bit("pending flag set", 1'b1, is_seg ? s_pend2 : r_pend2);
    // A stale tag must not retire the register
    @(negedge clk);
    drive_writeback(is_seg, idx, rrag_pkg::ptcid_t'(tag + 1));
    #1;
    compare_bit("stall after stale writeback", 1'b1, stall);
    compare_ptcid("tag held by stall", exp_ptcid, inst_ptcid);
    @(negedge clk);
    valid_in = 1'b0;
    drive_writeback(is_seg, idx, tag);
    #1;
    compare_bit("stall cleared by matching writeback", 1'b0, stall);
    compare_bit("pending flag cleared", 1'b0, is_seg ? s_pend2 : r_pend2);
    @(negedge clk);
    {mem1_rw, mem2_rw, usereg2} = '0;
endtask

task automatic pending_stall();
    pending_case(1'b0, 3);
    pending_case(1'b1, 5);
endtask

task automatic tag_sequence();
    @(negedge clk);
    valid_in = 1'b1;
    for (int i = 0; i < 6; i++) begin
        #1;
        compare_ptcid("tag while issuing", exp_ptcid, inst_ptcid);
        @(negedge clk);
        exp_ptcid++;
    end
    fwd_stall = 1'b1;
    for (int i = 0; i < 3; i++) begin
        #1;
        compare_ptcid("tag under fwd_stall", exp_ptcid, inst_ptcid);
        @(negedge clk);
    end
    fwd_stall = 1'b0;
    latch_empty = 1'b1;
    for (int i = 0; i < 3; i++) begin
        #1;
        compare_ptcid("tag under latch_empty", exp_ptcid, inst_ptcid);
        @(negedge clk);
    end
    latch_empty = 1'b0;
    dest_gpr = '1;
    dest_seg = '1;
    @(negedge clk);
    exp_ptcid++;
    {valid_in, dest_gpr, dest_seg} = '0;
    pend_scan(1'b1, "pending after issue");
    ptc_clear = 1'b1;
    @(negedge clk);
    ptc_clear = 1'b0;
    pend_scan(1'b0, "pending after ptc_clear");
endtask

task automatic pass_through();
    rrag_pkg::gpr_t exp_rep;
    // Held stall keeps valid_in from issuing
    fwd_stall = 1'b1;
    for (int c = 0; c < 4; c++) begin
        valid_in = c[0];
        latch_empty = c[1];
        #1;
        compare_bit("valid_out", c[0] && !c[1], valid_out);
        @(negedge clk);
    end
    {valid_in, latch_empty} = '0;
    opsize_in = 2'd2;
    mem1_rw = 2'b11;
    usereg2 = 1'b1;
    for (int i = 0; i < 8; i++) begin
        is_rep_in = 1'($urandom);
        fwd_stall = 1'($urandom);
        reg_addr4 = rrag_pkg::reg_idx_t'($urandom);
        #1;
        exp_rep = is_rep_in ? gpr_model[reg_addr4] : '0;
        compare_gpr("rep_num", exp_rep, rep_num);
        compare_bit("stall follows fwd_stall", fwd_stall, stall);
        @(negedge clk);
    end
    {fwd_stall, is_rep_in, mem1_rw, usereg2} = '0;
    compare_ptcid("final tag", exp_ptcid, inst_ptcid);
endtask

//--- dv/rrag_tb.sv
`timescale 1ns/100ps

module rrag_tb;

    logic                clk;
    logic                rst_n;
    logic                valid_in, latch_empty, fwd_stall, ptc_clear;
    rrag_pkg::reg_idx_t  reg_addr1, reg_addr2, reg_addr3, reg_addr4;
    rrag_pkg::reg_idx_t  seg_addr1, seg_addr2, seg_addr3, seg_addr4;
    rrag_pkg::opsize_t   opsize_in;
    rrag_pkg::shamt_t    reg3_shfamnt;
    logic                usereg2, usereg3, is_rep_in;
    logic [1:0]          mem1_rw, mem2_rw;
    rrag_pkg::addr_t     disp;
    rrag_pkg::reg_mask_t dest_gpr, dest_seg;
    rrag_pkg::gpr_t      wba_data, wbb_data;
    rrag_pkg::reg_idx_t  wba_addr, wbb_addr, wba_segaddr, wbb_segaddr;
    logic                wba_regld, wbb_regld, wba_segld, wbb_segld;
    rrag_pkg::opsize_t   wba_opsize, wbb_opsize;
    rrag_pkg::seg_t      wba_segdata, wbb_segdata;
    rrag_pkg::ptcid_t    wba_ptcid, wbb_ptcid;

    logic                valid_out, stall;
    rrag_pkg::ptcid_t    inst_ptcid;
    rrag_pkg::gpr_t      reg1, reg2, reg3, reg4, rep_num;
    rrag_pkg::seg_t      seg1, seg2, seg3, seg4;
    logic                r_pend1, r_pend2, r_pend3, r_pend4;
    logic                s_pend1, s_pend2, s_pend3, s_pend4;
    rrag_pkg::addr_t     mem_addr1, mem_addr2, mem_addr1_end, mem_addr2_end;

    // Expected register contents and next instruction tag
    rrag_pkg::gpr_t      gpr_model [rrag_pkg::NUM_REGS];
    rrag_pkg::seg_t      seg_model [rrag_pkg::NUM_REGS];
    rrag_pkg::ptcid_t    exp_ptcid;

    string               test_name;
    int                  errors;
    int                  test_start_errors;
    int                  tests_run;
    int                  tests_failed;

    rrag i_rrag (.*);

    task automatic report_mismatch(input string what, input string exp, input string act);
        $display("** Error %s: %s expected %s actual %s", test_name, what, exp, act);
        errors++;
    endtask

    task automatic compare_gpr(input string what, input rrag_pkg::gpr_t exp,
                               input rrag_pkg::gpr_t act);
        if (act !== exp)
            report_mismatch(what, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic compare_seg(input string what, input rrag_pkg::seg_t exp,
                               input rrag_pkg::seg_t act);
        if (act !== exp)
            report_mismatch(what, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic compare_addr(input string what, input rrag_pkg::addr_t exp,
                                input rrag_pkg::addr_t act);
        if (act !== exp)
            report_mismatch(what, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic compare_ptcid(input string what, input rrag_pkg::ptcid_t exp,
                                 input rrag_pkg::ptcid_t act);
        if (act !== exp)
            report_mismatch(what, $sformatf("%0d", exp), $sformatf("%0d", act));
    endtask

    task automatic compare_bit(input string what, input logic exp, input logic act);
        if (act !== exp)
            report_mismatch(what, $sformatf("%b", exp), $sformatf("%b", act));
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_start_errors = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == test_start_errors) begin
            $display("test %s passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", test_name, errors - test_start_errors);
        end
    endtask

    `include "rrag_tests.svh"

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        void'($urandom(19032));
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        exp_ptcid = '0;
        for (int r = 0; r < rrag_pkg::NUM_REGS; r++) begin
            gpr_model[r] = '0;
            seg_model[r] = '0;
        end
        idle_inputs();
        rst_n = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        start_test("sized_access");
        sized_access();
        end_test();
        start_test("address_math");
        address_math();
        end_test();
        start_test("pending_stall");
        pending_stall();
        end_test();
        start_test("tag_sequence");
        tag_sequence();
        end_test();
        start_test("pass_through");
        pass_through();
        end_test();

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- rtl/addr_gen.sv
`timescale 1ns/100ps

module addr_gen (
    input  rrag_pkg::gpr_t    reg2,
    input  rrag_pkg::gpr_t    reg3,
    input  rrag_pkg::gpr_t    reg4,
    input  rrag_pkg::seg_t    seg1,
    input  rrag_pkg::seg_t    seg2,
    input  rrag_pkg::addr_t   disp,
    input  logic              usereg2,
    input  logic              usereg3,
    input  rrag_pkg::shamt_t  reg3_shfamnt,
    input  rrag_pkg::opsize_t opsize,
    output rrag_pkg::addr_t   mem_addr1,
    output rrag_pkg::addr_t   mem_addr2,
    output rrag_pkg::addr_t   mem_addr1_end,
    output rrag_pkg::addr_t   mem_addr2_end
);

    rrag_pkg::addr_t base;
    rrag_pkg::addr_t index;
    rrag_pkg::addr_t offset;
    rrag_pkg::addr_t seg1_lin;
    rrag_pkg::addr_t seg2_lin;
    rrag_pkg::addr_t span;

    // Base plus scaled index, as from ModRM/SIB
    assign base   = usereg2 ? reg2 : '0;
    assign index  = usereg3 ? (reg3 << reg3_shfamnt) : '0;
    assign offset = base + index;

    assign seg1_lin = rrag_pkg::addr_t'(seg1) << rrag_pkg::SEG_SHIFT;
    assign seg2_lin = rrag_pkg::addr_t'(seg2) << rrag_pkg::SEG_SHIFT;

    assign mem_addr1 = offset + disp + seg1_lin;
    assign mem_addr2 = reg4 + seg2_lin;

    // Last byte touched, 1/2/4/8 byte operand
    assign span = (rrag_pkg::addr_t'(1) << opsize) - rrag_pkg::addr_t'(1);

    assign mem_addr1_end = offset + disp + span;
    assign mem_addr2_end = reg4 + span;

endmodule

//--- rtl/ptc_generator.sv
`timescale 1ns/100ps

module ptc_generator (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             next,
    output rrag_pkg::ptcid_t ptcid
);

    // Wraps from 127 back to 0 by width
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ptcid <= '0;
        end else if (next) begin
            ptcid <= ptcid + rrag_pkg::ptcid_t'(1);
        end
    end

    a_tag_holds: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) && !$past(next) |-> $stable(ptcid))
        else $error("instruction tag moved without an issue");

endmodule

//--- rtl/regfile.sv
`timescale 1ns/100ps

module regfile (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                issue,
    input  logic                ptc_clear,
    input  rrag_pkg::reg_mask_t dest,
    input  rrag_pkg::ptcid_t    new_ptcid,
    input  rrag_pkg::opsize_t   rdsize,
    input  rrag_pkg::reg_idx_t  rd_addr1,
    input  rrag_pkg::reg_idx_t  rd_addr2,
    input  rrag_pkg::reg_idx_t  rd_addr3,
    input  rrag_pkg::reg_idx_t  rd_addr4,
    input  rrag_pkg::gpr_t      wba_data,
    input  rrag_pkg::reg_idx_t  wba_addr,
    input  logic                wba_ld,
    input  rrag_pkg::opsize_t   wba_opsize,
    input  rrag_pkg::ptcid_t    wba_ptcid,
    input  rrag_pkg::gpr_t      wbb_data,
    input  rrag_pkg::reg_idx_t  wbb_addr,
    input  logic                wbb_ld,
    input  rrag_pkg::opsize_t   wbb_opsize,
    input  rrag_pkg::ptcid_t    wbb_ptcid,
    output rrag_pkg::gpr_t      dout1,
    output rrag_pkg::gpr_t      dout2,
    output rrag_pkg::gpr_t      dout3,
    output rrag_pkg::gpr_t      dout4,
    output logic                pend1,
    output logic                pend2,
    output logic                pend3,
    output logic                pend4
);

    rrag_pkg::gpr_t      regs [rrag_pkg::NUM_REGS];
    rrag_pkg::ptcid_t    tags [rrag_pkg::NUM_REGS];
    rrag_pkg::reg_mask_t pend;
    rrag_pkg::reg_mask_t hit_a;
    rrag_pkg::reg_mask_t hit_b;
    rrag_pkg::reg_mask_t tag_hit;

    // Narrow writes keep the upper bits of the old value
    function automatic rrag_pkg::gpr_t merge(input rrag_pkg::gpr_t old_val,
                                             input rrag_pkg::gpr_t new_val,
                                             input rrag_pkg::opsize_t size);
        case (size)
            rrag_pkg::SIZE_BYTE: return {old_val[rrag_pkg::GPR_W-1:8], new_val[7:0]};
            rrag_pkg::SIZE_WORD: return {old_val[rrag_pkg::GPR_W-1:16], new_val[15:0]};
            default:             return new_val;
        endcase
    endfunction

    function automatic rrag_pkg::gpr_t size_read(input rrag_pkg::gpr_t val,
                                                 input rrag_pkg::opsize_t size);
        case (size)
            rrag_pkg::SIZE_BYTE:  return {{(rrag_pkg::GPR_W-8){1'b0}}, val[7:0]};
            rrag_pkg::SIZE_WORD:  return {{(rrag_pkg::GPR_W-16){1'b0}}, val[15:0]};
            rrag_pkg::SIZE_DWORD,
            rrag_pkg::SIZE_QWORD: return val;
            default:              return val;
        endcase
    endfunction

    always_comb begin
        for (int r = 0; r < rrag_pkg::NUM_REGS; r++) begin
            hit_a[r]   = wba_ld && (wba_addr == rrag_pkg::reg_idx_t'(r));
            hit_b[r]   = wbb_ld && (wbb_addr == rrag_pkg::reg_idx_t'(r));
            tag_hit[r] = (hit_a[r] && (wba_ptcid == tags[r])) ||
                         (hit_b[r] && (wbb_ptcid == tags[r]));
        end
    end

    always_ff @(posedge clk) begin
        for (int r = 0; r < rrag_pkg::NUM_REGS; r++) begin
            if (!rst_n) begin
                regs[r] <= '0;
            end else if (hit_a[r]) begin
                regs[r] <= merge(regs[r], wba_data, wba_opsize);
            end else if (hit_b[r]) begin
                regs[r] <= merge(regs[r], wbb_data, wbb_opsize);
            end
        end
    end

    // Flush first, then new owner, then retiring writer
    always_ff @(posedge clk) begin
        for (int r = 0; r < rrag_pkg::NUM_REGS; r++) begin
            if (!rst_n || ptc_clear) begin
                pend[r] <= 1'b0;
            end else if (issue && dest[r]) begin
                pend[r] <= 1'b1;
            end else if (tag_hit[r]) begin
                pend[r] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int r = 0; r < rrag_pkg::NUM_REGS; r++) begin
            if (issue && dest[r]) begin
                tags[r] <= new_ptcid;
            end
        end
    end

    assign dout1 = size_read(regs[rd_addr1], rdsize);
    assign dout2 = size_read(regs[rd_addr2], rdsize);
    assign dout3 = size_read(regs[rd_addr3], rdsize);
    assign dout4 = size_read(regs[rd_addr4], rdsize);

    assign pend1 = pend[rd_addr1];
    assign pend2 = pend[rd_addr2];
    assign pend3 = pend[rd_addr3];
    assign pend4 = pend[rd_addr4];

    a_no_dual_write: assert property (@(posedge clk) disable iff (!rst_n)
        !(wba_ld && wbb_ld && (wba_addr == wbb_addr)))
        else $error("both writeback ports load the same general register");

endmodule

//--- rtl/rrag.sv
`timescale 1ns/100ps

module rrag (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                valid_in,
    input  logic                latch_empty,
    input  logic                fwd_stall,
    input  logic                ptc_clear,
    input  rrag_pkg::reg_idx_t  reg_addr1,
    input  rrag_pkg::reg_idx_t  reg_addr2,
    input  rrag_pkg::reg_idx_t  reg_addr3,
    input  rrag_pkg::reg_idx_t  reg_addr4,
    input  rrag_pkg::reg_idx_t  seg_addr1,
    input  rrag_pkg::reg_idx_t  seg_addr2,
    input  rrag_pkg::reg_idx_t  seg_addr3,
    input  rrag_pkg::reg_idx_t  seg_addr4,
    input  rrag_pkg::opsize_t   opsize_in,
    input  rrag_pkg::shamt_t    reg3_shfamnt,
    input  logic                usereg2,
    input  logic                usereg3,
    input  logic                is_rep_in,
    input  logic [1:0]          mem1_rw,
    input  logic [1:0]          mem2_rw,
    input  rrag_pkg::addr_t     disp,
    input  rrag_pkg::reg_mask_t dest_gpr,
    input  rrag_pkg::reg_mask_t dest_seg,
    input  rrag_pkg::gpr_t      wba_data,
    input  rrag_pkg::reg_idx_t  wba_addr,
    input  logic                wba_regld,
    input  rrag_pkg::opsize_t   wba_opsize,
    input  rrag_pkg::seg_t      wba_segdata,
    input  rrag_pkg::reg_idx_t  wba_segaddr,
    input  logic                wba_segld,
    input  rrag_pkg::ptcid_t    wba_ptcid,
    input  rrag_pkg::gpr_t      wbb_data,
    input  rrag_pkg::reg_idx_t  wbb_addr,
    input  logic                wbb_regld,
    input  rrag_pkg::opsize_t   wbb_opsize,
    input  rrag_pkg::seg_t      wbb_segdata,
    input  rrag_pkg::reg_idx_t  wbb_segaddr,
    input  logic                wbb_segld,
    input  rrag_pkg::ptcid_t    wbb_ptcid,
    output logic                valid_out,
    output logic                stall,
    output rrag_pkg::ptcid_t    inst_ptcid,
    output rrag_pkg::gpr_t      reg1,
    output rrag_pkg::gpr_t      reg2,
    output rrag_pkg::gpr_t      reg3,
    output rrag_pkg::gpr_t      reg4,
    output rrag_pkg::seg_t      seg1,
    output rrag_pkg::seg_t      seg2,
    output rrag_pkg::seg_t      seg3,
    output rrag_pkg::seg_t      seg4,
    output logic                r_pend1,
    output logic                r_pend2,
    output logic                r_pend3,
    output logic                r_pend4,
    output logic                s_pend1,
    output logic                s_pend2,
    output logic                s_pend3,
    output logic                s_pend4,
    output rrag_pkg::addr_t     mem_addr1,
    output rrag_pkg::addr_t     mem_addr2,
    output rrag_pkg::addr_t     mem_addr1_end,
    output rrag_pkg::addr_t     mem_addr2_end,
    output rrag_pkg::gpr_t      rep_num
);

    logic issue;
    logic mem1_use;
    logic mem2_use;
    logic mem1_stall;
    logic mem2_stall;

    assign valid_out = valid_in && !latch_empty;
    assign issue     = valid_out && !stall;

    ptc_generator i_ptcgen (
        .clk   (clk),
        .rst_n (rst_n),
        .next  (issue),
        .ptcid (inst_ptcid)
    );

    regfile i_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .issue      (issue),
        .ptc_clear  (ptc_clear),
        .dest       (dest_gpr),
        .new_ptcid  (inst_ptcid),
        .rdsize     (opsize_in),
        .rd_addr1   (reg_addr1),
        .rd_addr2   (reg_addr2),
        .rd_addr3   (reg_addr3),
        .rd_addr4   (reg_addr4),
        .wba_data   (wba_data),
        .wba_addr   (wba_addr),
        .wba_ld     (wba_regld),
        .wba_opsize (wba_opsize),
        .wba_ptcid  (wba_ptcid),
        .wbb_data   (wbb_data),
        .wbb_addr   (wbb_addr),
        .wbb_ld     (wbb_regld),
        .wbb_opsize (wbb_opsize),
        .wbb_ptcid  (wbb_ptcid),
        .dout1      (reg1),
        .dout2      (reg2),
        .dout3      (reg3),
        .dout4      (reg4),
        .pend1      (r_pend1),
        .pend2      (r_pend2),
        .pend3      (r_pend3),
        .pend4      (r_pend4)
    );

    segfile i_segfile (
        .clk       (clk),
        .rst_n     (rst_n),
        .issue     (issue),
        .ptc_clear (ptc_clear),
        .dest      (dest_seg),
        .new_ptcid (inst_ptcid),
        .rd_addr1  (seg_addr1),
        .rd_addr2  (seg_addr2),
        .rd_addr3  (seg_addr3),
        .rd_addr4  (seg_addr4),
        .wba_data  (wba_segdata),
        .wba_addr  (wba_segaddr),
        .wba_ld    (wba_segld),
        .wba_ptcid (wba_ptcid),
        .wbb_data  (wbb_segdata),
        .wbb_addr  (wbb_segaddr),
        .wbb_ld    (wbb_segld),
        .wbb_ptcid (wbb_ptcid),
        .dout1     (seg1),
        .dout2     (seg2),
        .dout3     (seg3),
        .dout4     (seg4),
        .pend1     (s_pend1),
        .pend2     (s_pend2),
        .pend3     (s_pend3),
        .pend4     (s_pend4)
    );

    addr_gen i_addr_gen (
        .reg2          (reg2),
        .reg3          (reg3),
        .reg4          (reg4),
        .seg1          (seg1),
        .seg2          (seg2),
        .disp          (disp),
        .usereg2       (usereg2),
        .usereg3       (usereg3),
        .reg3_shfamnt  (reg3_shfamnt),
        .opsize        (opsize_in),
        .mem_addr1     (mem_addr1),
        .mem_addr2     (mem_addr2),
        .mem_addr1_end (mem_addr1_end),
        .mem_addr2_end (mem_addr2_end)
    );

    // Address operands must not wait on an older writer
    assign mem1_use   = |mem1_rw;
    assign mem2_use   = |mem2_rw;
    assign mem1_stall = mem1_use && ((usereg2 && r_pend2) || (usereg3 && r_pend3) || s_pend1);
    assign mem2_stall = mem2_use && (r_pend4 || s_pend2);
    assign stall      = fwd_stall || mem1_stall || mem2_stall;

    // Count register for string ops
    assign rep_num = is_rep_in ? reg4 : '0;

    a_stall_cause: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(stall) |-> fwd_stall ||
            ((mem1_use || mem2_use) &&
             (r_pend2 || r_pend3 || r_pend4 || s_pend1 || s_pend2)))
        else $error("stall raised without a cause");

endmodule

//--- rtl/rrag_pkg.sv
package rrag_pkg;

    // Register file geometry
    localparam int NUM_REGS  = 8;
    localparam int REG_IDX_W = $clog2(NUM_REGS);

    // Datapath widths
    localparam int GPR_W   = 32;
    localparam int SEG_W   = 16;
    localparam int ADDR_W  = 32;
    localparam int PTCID_W = 7;

    // Segment value sits above the offset in linear address math
    localparam int SEG_SHIFT = 16;

    typedef logic [GPR_W-1:0]     gpr_t;
    typedef logic [SEG_W-1:0]     seg_t;
    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [NUM_REGS-1:0]  reg_mask_t;
    typedef logic [PTCID_W-1:0]   ptcid_t;
    typedef logic [1:0]           opsize_t;
    typedef logic [1:0]           shamt_t;

    // Operand size encodings
    localparam opsize_t SIZE_BYTE  = 2'd0;
    localparam opsize_t SIZE_WORD  = 2'd1;
    localparam opsize_t SIZE_DWORD = 2'd2;
    localparam opsize_t SIZE_QWORD = 2'd3;

endpackage

//--- rtl/segfile.sv
`timescale 1ns/100ps

module segfile (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                issue,
    input  logic                ptc_clear,
    input  rrag_pkg::reg_mask_t dest,
    input  rrag_pkg::ptcid_t    new_ptcid,
    input  rrag_pkg::reg_idx_t  rd_addr1,
    input  rrag_pkg::reg_idx_t  rd_addr2,
    input  rrag_pkg::reg_idx_t  rd_addr3,
    input  rrag_pkg::reg_idx_t  rd_addr4,
    input  rrag_pkg::seg_t      wba_data,
    input  rrag_pkg::reg_idx_t  wba_addr,
    input  logic                wba_ld,
    input  rrag_pkg::ptcid_t    wba_ptcid,
    input  rrag_pkg::seg_t      wbb_data,
    input  rrag_pkg::reg_idx_t  wbb_addr,
    input  logic                wbb_ld,
    input  rrag_pkg::ptcid_t    wbb_ptcid,
    output rrag_pkg::seg_t      dout1,
    output rrag_pkg::seg_t      dout2,
    output rrag_pkg::seg_t      dout3,
    output rrag_pkg::seg_t      dout4,
    output logic                pend1,
    output logic                pend2,
    output logic                pend3,
    output logic                pend4
);

    rrag_pkg::seg_t      segs [rrag_pkg::NUM_REGS];
    rrag_pkg::ptcid_t    tags [rrag_pkg::NUM_REGS];
    rrag_pkg::reg_mask_t pend;
    rrag_pkg::reg_mask_t hit_a;
    rrag_pkg::reg_mask_t hit_b;
    rrag_pkg::reg_mask_t tag_hit;

    always_comb begin
        for (int r = 0; r < rrag_pkg::NUM_REGS; r++) begin
            hit_a[r]   = wba_ld && (wba_addr == rrag_pkg::reg_idx_t'(r));
            hit_b[r]   = wbb_ld && (wbb_addr == rrag_pkg::reg_idx_t'(r));
            tag_hit[r] = (hit_a[r] && (wba_ptcid == tags[r])) ||
                         (hit_b[r] && (wbb_ptcid == tags[r]));
        end
    end

    // Segment loads are always full width
    always_ff @(posedge clk) begin
        for (int r = 0; r < rrag_pkg::NUM_REGS; r++) begin
            if (!rst_n) begin
                segs[r] <= '0;
            end else if (hit_a[r]) begin
                segs[r] <= wba_data;
            end else if (hit_b[r]) begin
                segs[r] <= wbb_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int r = 0; r < rrag_pkg::NUM_REGS; r++) begin
            if (!rst_n || ptc_clear) begin
                pend[r] <= 1'b0;
            end else if (issue && dest[r]) begin
                pend[r] <= 1'b1;
            end else if (tag_hit[r]) begin
                pend[r] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int r = 0; r < rrag_pkg::NUM_REGS; r++) begin
            if (issue && dest[r]) begin
                tags[r] <= new_ptcid;
            end
        end
    end

    assign dout1 = segs[rd_addr1];
    assign dout2 = segs[rd_addr2];
    assign dout3 = segs[rd_addr3];
    assign dout4 = segs[rd_addr4];

    assign pend1 = pend[rd_addr1];
    assign pend2 = pend[rd_addr2];
    assign pend3 = pend[rd_addr3];
    assign pend4 = pend[rd_addr4];

    a_no_dual_write: assert property (@(posedge clk) disable iff (!rst_n)
        !(wba_ld && wbb_ld && (wba_addr == wbb_addr)))
        else $error("both writeback ports load the same segment register");

endmodule

//--- run.sh
#!/bin/sh
# Build and run the rrag testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module rrag_tb -o rrag_sim \
    > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/rrag_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^PASS: all tests$" sim.log; then
    echo "Run passed"
    exit 0
fi

echo "Run failed, see sim.log"
exit 1
